//--- source/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    typedef enum logic [1:0] {
        MSIZE_BYTE = 2'd0,
        MSIZE_HALF = 2'd1,
        MSIZE_WORD = 2'd2
    } msize_t;

    // one load lane of a bundle, 36 bits
    typedef struct packed {
        logic   valid;
        addr_t  addr;
        msize_t msize;
        logic   sext;
    } lane_req_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        WAIT  = 2'd2,
        DONE  = 2'd3
    } ctrl_state_t;

    localparam int unsigned DEFAULT_CACHED_LATENCY   = 2;
    localparam int unsigned DEFAULT_UNCACHED_LATENCY = 6;
    localparam int unsigned UNCACHED_BIT             = 29;
    localparam int unsigned DMEM_WORDS               = 32;

endpackage

//--- source/dbus_if.sv
`timescale 1ns/1ps

interface dbus_if;

    // request, single-cycle pulse
    logic            valid;
    mem_pkg::addr_t  addr;
    mem_pkg::msize_t msize;

    // response, one data_ok per request
    mem_pkg::word_t  data;
    logic            data_ok;

    modport master (output valid, addr, msize, input data, data_ok);
    modport slave (input valid, addr, msize, output data, data_ok);

endinterface

//--- source/latency_timer.sv
`timescale 1ns/1ps

module latency_timer (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  logic [7:0] cycles,
    output logic       busy,
    output logic       expired
);

    logic [7:0] count;

    always_ff @(posedge clk) begin
        if (resetn) begin
            count <= '0;
        end else if (start) begin
            count <= cycles;
        end else if (busy) begin
            count <= count - 8'd1;
        end
    end

    assign busy    = (count != 8'd0);
    // count of 1 is the last waiting cycle
    assign expired = (count == 8'd1);

endmodule

//--- source/bundle_ctrl.sv
`timescale 1ns/1ps

module bundle_ctrl (
    input  logic                clk,
    input  logic                resetn,
    input  logic                bundle_valid,
    input  mem_pkg::lane_req_t  lane0_in,
    input  mem_pkg::lane_req_t  lane1_in,
    input  logic                lane0_done,
    input  logic                lane1_done,
    input  logic                result_ready,
    output logic                bundle_ready,
    output logic                result_valid,
    output logic                clear,
    output mem_pkg::lane_req_t  lane0_req,
    output mem_pkg::lane_req_t  lane1_req,
    dbus_if.master              dbus0,
    dbus_if.master              dbus1
);

    mem_pkg::ctrl_state_t state;
    mem_pkg::lane_req_t   lane0_q;
    mem_pkg::lane_req_t   lane1_q;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state   <= mem_pkg::IDLE;
            lane0_q <= '0;
            lane1_q <= '0;
        end else begin
            unique case (state)
                mem_pkg::IDLE: begin
                    if (bundle_valid) begin
                        lane0_q <= lane0_in;
                        lane1_q <= lane1_in;
                        state   <= mem_pkg::ISSUE;
                    end
                end
                // requests go out during this single cycle
                mem_pkg::ISSUE: state <= mem_pkg::WAIT;
                mem_pkg::WAIT: begin
                    if (lane0_done && lane1_done) begin
                        state <= mem_pkg::DONE;
                    end
                end
                mem_pkg::DONE: begin
                    if (result_ready) begin
                        state <= mem_pkg::IDLE;
                    end
                end
                default: state <= mem_pkg::IDLE;
            endcase
        end
    end

    assign bundle_ready = (state == mem_pkg::IDLE);
    assign result_valid = (state == mem_pkg::DONE);
    // lanes drop their saved words on hand-off
    assign clear        = result_valid && result_ready;

    assign lane0_req = lane0_q;
    assign lane1_req = lane1_q;

    assign dbus0.valid = (state == mem_pkg::ISSUE) && lane0_q.valid;
    assign dbus0.addr  = lane0_q.addr;
    assign dbus0.msize = lane0_q.msize;

    assign dbus1.valid = (state == mem_pkg::ISSUE) && lane1_q.valid;
    assign dbus1.addr  = lane1_q.addr;
    assign dbus1.msize = lane1_q.msize;

endmodule

//--- source/load_lane.sv
`timescale 1ns/1ps

module load_lane (
    input  logic               clk,
    input  logic               resetn,
    input  logic               clear,
    input  mem_pkg::lane_req_t req,
    dbus_if.master             dbus,
    output logic               done,
    output mem_pkg::word_t     result_data
);

    mem_pkg::word_t word_q;
    logic           saved;
    logic [7:0]     sel_byte;
    logic [15:0]    sel_half;

    // an early answer waits here for the other lane
    always_ff @(posedge clk) begin
        if (resetn) begin
            saved <= 1'b0;
        end else if (clear) begin
            saved <= 1'b0;
        end else if (dbus.data_ok) begin
            saved <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dbus.data_ok) begin
            word_q <= dbus.data;
        end
    end

    assign done = saved || !req.valid;

    // low address bits pick the byte or half within the word
    assign sel_byte = word_q[{req.addr[1:0], 3'b000} +: 8];
    assign sel_half = req.addr[1] ? word_q[31:16] : word_q[15:0];

    always_comb begin
        if (!req.valid) begin
            result_data = '0;
        end else begin
            unique case (req.msize)
                mem_pkg::MSIZE_BYTE: begin
                    result_data = {{24{req.sext & sel_byte[7]}}, sel_byte};
                end
                mem_pkg::MSIZE_HALF: begin
                    result_data = {{16{req.sext & sel_half[15]}}, sel_half};
                end
                default: begin
                    result_data = word_q;
                end
            endcase
        end
    end

endmodule

//--- source/dual_port_dmem.sv
`timescale 1ns/1ps

module dual_port_dmem #(
    parameter int unsigned CACHED_LATENCY   = mem_pkg::DEFAULT_CACHED_LATENCY,
    parameter int unsigned UNCACHED_LATENCY = mem_pkg::DEFAULT_UNCACHED_LATENCY
) (
    input  logic    clk,
    input  logic    resetn,
    dbus_if.slave   port0,
    dbus_if.slave   port1
);

    mem_pkg::word_t mem [mem_pkg::DMEM_WORDS];
    mem_pkg::word_t word0_q;
    mem_pkg::word_t word1_q;
    logic [7:0]     cycles0;
    logic [7:0]     cycles1;
    logic           start0;
    logic           start1;
    logic           busy0;
    logic           busy1;

    initial begin
        $readmemh("dmem_init.hex", mem);
    end

    // only the accessed bytes come back, the rest read as zero
    function automatic mem_pkg::word_t byte_mask(input logic [1:0] offset,
                                                 input mem_pkg::msize_t msize);
        unique case (msize)
            mem_pkg::MSIZE_BYTE: return 32'h0000_00ff << {offset, 3'b000};
            mem_pkg::MSIZE_HALF: return offset[1] ? 32'hffff_0000 : 32'h0000_ffff;
            default:             return 32'hffff_ffff;
        endcase
    endfunction

    // uncached window takes the long path
    assign cycles0 = port0.addr[mem_pkg::UNCACHED_BIT] ? 8'(UNCACHED_LATENCY)
                                                       : 8'(CACHED_LATENCY);
    assign cycles1 = port1.addr[mem_pkg::UNCACHED_BIT] ? 8'(UNCACHED_LATENCY)
                                                       : 8'(CACHED_LATENCY);

    assign start0 = port0.valid && !busy0;
    assign start1 = port1.valid && !busy1;

    always_ff @(posedge clk) begin
        if (start0) begin
            word0_q <= mem[port0.addr[6:2]] & byte_mask(port0.addr[1:0], port0.msize);
        end
        if (start1) begin
            word1_q <= mem[port1.addr[6:2]] & byte_mask(port1.addr[1:0], port1.msize);
        end
    end

    latency_timer timer0 (
        .clk     (clk),
        .resetn  (resetn),
        .start   (start0),
        .cycles  (cycles0),
        .busy    (busy0),
        .expired (port0.data_ok)
    );

    latency_timer timer1 (
        .clk     (clk),
        .resetn  (resetn),
        .start   (start1),
        .cycles  (cycles1),
        .busy    (busy1),
        .expired (port1.data_ok)
    );

    assign port0.data = word0_q;
    assign port1.data = word1_q;

endmodule

//--- source/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top #(
    parameter int unsigned CACHED_LATENCY   = mem_pkg::DEFAULT_CACHED_LATENCY,
    parameter int unsigned UNCACHED_LATENCY = mem_pkg::DEFAULT_UNCACHED_LATENCY
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            bundle_valid,
    input  logic            result_ready,
    input  logic            lane0_valid,
    input  mem_pkg::addr_t  lane0_addr,
    input  mem_pkg::msize_t lane0_msize,
    input  logic            lane0_sext,
    input  logic            lane1_valid,
    input  mem_pkg::addr_t  lane1_addr,
    input  mem_pkg::msize_t lane1_msize,
    input  logic            lane1_sext,
    output logic            bundle_ready,
    output logic            result_valid,
    output mem_pkg::word_t  result0_data,
    output mem_pkg::word_t  result1_data
);

    mem_pkg::lane_req_t lane0_in;
    mem_pkg::lane_req_t lane1_in;
    mem_pkg::lane_req_t lane0_req;
    mem_pkg::lane_req_t lane1_req;
    logic               lane0_done;
    logic               lane1_done;
    logic               clear;

    dbus_if dbus0 ();
    dbus_if dbus1 ();

    assign lane0_in = '{valid: lane0_valid, addr: lane0_addr, msize: lane0_msize,
                        sext: lane0_sext};
    assign lane1_in = '{valid: lane1_valid, addr: lane1_addr, msize: lane1_msize,
                        sext: lane1_sext};

    bundle_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .bundle_valid (bundle_valid),
        .lane0_in     (lane0_in),
        .lane1_in     (lane1_in),
        .lane0_done   (lane0_done),
        .lane1_done   (lane1_done),
        .result_ready (result_ready),
        .bundle_ready (bundle_ready),
        .result_valid (result_valid),
        .clear        (clear),
        .lane0_req    (lane0_req),
        .lane1_req    (lane1_req),
        .dbus0        (dbus0.master),
        .dbus1        (dbus1.master)
    );

    load_lane u_lane0 (
        .clk         (clk),
        .resetn      (resetn),
        .clear       (clear),
        .req         (lane0_req),
        .dbus        (dbus0.master),
        .done        (lane0_done),
        .result_data (result0_data)
    );

    load_lane u_lane1 (
        .clk         (clk),
        .resetn      (resetn),
        .clear       (clear),
        .req         (lane1_req),
        .dbus        (dbus1.master),
        .done        (lane1_done),
        .result_data (result1_data)
    );

    dual_port_dmem #(
        .CACHED_LATENCY   (CACHED_LATENCY),
        .UNCACHED_LATENCY (UNCACHED_LATENCY)
    ) u_dmem (
        .clk    (clk),
        .resetn (resetn),
        .port0  (dbus0.slave),
        .port1  (dbus1.slave)
    );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- tests/mem_stage_checker.sv
`timescale 1ns/1ps

module mem_stage_checker (
    input logic                 clk,
    input logic                 resetn,
    input mem_pkg::ctrl_state_t state,
    input logic                 req0_valid,
    input logic                 req1_valid,
    input logic                 result_valid,
    input logic                 result_ready,
    input logic                 bundle_ready
);

    int assert_fails = 0;

    // request pulses last a single cycle
    req0_pulse: assert property (@(posedge clk) disable iff (resetn)
        req0_valid |=> !req0_valid)
        else begin
            $error("lane 0 request valid held for more than one cycle");
            assert_fails++;
        end

    req1_pulse: assert property (@(posedge clk) disable iff (resetn)
        req1_valid |=> !req1_valid)
        else begin
            $error("lane 1 request valid held for more than one cycle");
            assert_fails++;
        end

    // result stays offered until taken
    result_hold: assert property (@(posedge clk) disable iff (resetn)
        result_valid && !result_ready |=> result_valid)
        else begin
            $error("result_valid dropped before the result was taken");
            assert_fails++;
        end

    // no return to IDLE except through the hand-off
    ready_low_busy: assert property (@(posedge clk) disable iff (resetn)
        state != mem_pkg::IDLE && !(result_valid && result_ready) |=> !bundle_ready)
        else begin
            $error("bundle_ready rose before the result was taken");
            assert_fails++;
        end

endmodule

bind bundle_ctrl mem_stage_checker u_checker (
    .clk          (clk),
    .resetn       (resetn),
    .state        (state),
    .req0_valid   (dbus0.valid),
    .req1_valid   (dbus1.valid),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .bundle_ready (bundle_ready)
);

//--- tests/mem_stage_monitor.sv
`timescale 1ns/1ps

module mem_stage_monitor (
    input  logic               clk,
    input  logic               resetn,
    input  logic               bundle_valid,
    input  logic               bundle_ready,
    input  logic               result_valid,
    input  logic               result_ready,
    input  mem_pkg::lane_req_t lane0,
    input  mem_pkg::lane_req_t lane1,
    input  mem_pkg::word_t     result0_data,
    input  mem_pkg::word_t     result1_data,
    output int                 check_count,
    output int                 error_count
);

    mem_pkg::word_t     mem_model [mem_pkg::DMEM_WORDS];
    mem_pkg::lane_req_t pend0 [$];
    mem_pkg::lane_req_t pend1 [$];
    mem_pkg::word_t     held0;
    mem_pkg::word_t     held1;
    logic               held;
    logic               timing;
    int                 since_accept;
    int                 min_cycles;

    initial begin
        $readmemh("dmem_init.hex", mem_model);
        check_count = 0;
        error_count = 0;
        held        = 1'b0;
        timing      = 1'b0;
    end

    // expected lane value from the load rules and the memory word
    function automatic mem_pkg::word_t expected_result(input mem_pkg::lane_req_t req,
                                                       input mem_pkg::word_t word);
        logic [7:0]  b;
        logic [15:0] h;
        if (!req.valid) begin
            return 32'h0;
        end
        case (req.addr[1:0])
            2'd0:    b = word[7:0];
            2'd1:    b = word[15:8];
            2'd2:    b = word[23:16];
            default: b = word[31:24];
        endcase
        h = req.addr[1] ? word[31:16] : word[15:0];
        case (req.msize)
            mem_pkg::MSIZE_BYTE: return (req.sext && b[7]) ? {24'hff_ffff, b} : {24'h0, b};
            mem_pkg::MSIZE_HALF: return (req.sext && h[15]) ? {16'hffff, h} : {16'h0, h};
            default:             return word;
        endcase
    endfunction

    function automatic int lane_latency(input mem_pkg::lane_req_t req);
        if (!req.valid) begin
            return 0;
        end
        return req.addr[mem_pkg::UNCACHED_BIT] ? mem_pkg::DEFAULT_UNCACHED_LATENCY
                                               : mem_pkg::DEFAULT_CACHED_LATENCY;
    endfunction

    task automatic compare_lane(input string name, input mem_pkg::lane_req_t req,
                                input mem_pkg::word_t actual);
        mem_pkg::word_t expected;
        expected = expected_result(req, mem_model[req.addr[6:2]]);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s expected %08h actual %08h (addr %08h msize %0d sext %0b)",
                     name, expected, actual, req.addr, req.msize, req.sext);
        end
    endtask

    always @(posedge clk) begin
        if (resetn) begin
            pend0.delete();
            pend1.delete();
            held   = 1'b0;
            timing = 1'b0;
        end else begin
            // result_valid rose on the edge before this one
            if (timing) begin
                since_accept++;
                if (result_valid) begin
                    timing = 1'b0;
                    if (since_accept - 1 < min_cycles) begin
                        error_count++;
                        $display("result arrived %0d cycles after acceptance, minimum is %0d",
                                 since_accept - 1, min_cycles);
                    end
                end
            end
            if (held) begin
                if (!result_valid) begin
                    error_count++;
                    $display("result_valid dropped while the result was not yet taken");
                end
                if (result0_data !== held0) begin
                    error_count++;
                    $display("FAILED result0_data held %08h changed to %08h", held0, result0_data);
                end
                if (result1_data !== held1) begin
                    error_count++;
                    $display("FAILED result1_data held %08h changed to %08h", held1, result1_data);
                end
                if (bundle_ready) begin
                    error_count++;
                    $display("bundle_ready went high while a result was waiting");
                end
            end
            held  = result_valid && !result_ready;
            held0 = result0_data;
            held1 = result1_data;
            if (result_valid && result_ready) begin
                if (pend0.size() == 0) begin
                    error_count++;
                    $display("a result was taken although no bundle was accepted");
                end else begin
                    compare_lane("result0_data", pend0.pop_front(), result0_data);
                    compare_lane("result1_data", pend1.pop_front(), result1_data);
                end
            end
            if (bundle_valid && bundle_ready) begin
                pend0.push_back(lane0);
                pend1.push_back(lane1);
                timing       = 1'b1;
                since_accept = 0;
                min_cycles   = 2 + ((lane_latency(lane0) > lane_latency(lane1))
                                    ? lane_latency(lane0) : lane_latency(lane1));
            end
        end
    end

endmodule

//--- tests/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;

    localparam int unsigned SEED       = 32'h0f25_17d1;
    localparam int          WAIT_LIMIT = 100;

    logic               clk;
    logic               resetn;
    logic               bundle_valid;
    logic               result_ready;
    logic               bundle_ready;
    logic               result_valid;
    mem_pkg::lane_req_t lane0;
    mem_pkg::lane_req_t lane1;
    mem_pkg::word_t     result0_data;
    mem_pkg::word_t     result1_data;
    int                 check_count;
    int                 error_count;
    int                 timeout_count;
    int                 assert_fails;
    logic               abort;
    int unsigned        seed_val;

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

    mem_stage_top dut (
        .clk          (clk),
        .resetn       (resetn),
        .bundle_valid (bundle_valid),
        .result_ready (result_ready),
        .lane0_valid  (lane0.valid),
        .lane0_addr   (lane0.addr),
        .lane0_msize  (lane0.msize),
        .lane0_sext   (lane0.sext),
        .lane1_valid  (lane1.valid),
        .lane1_addr   (lane1.addr),
        .lane1_msize  (lane1.msize),
        .lane1_sext   (lane1.sext),
        .bundle_ready (bundle_ready),
        .result_valid (result_valid),
        .result0_data (result0_data),
        .result1_data (result1_data)
    );

    mem_stage_monitor u_monitor (
        .clk          (clk),
        .resetn       (resetn),
        .bundle_valid (bundle_valid),
        .bundle_ready (bundle_ready),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .lane0        (lane0),
        .lane1        (lane1),
        .result0_data (result0_data),
        .result1_data (result1_data),
        .check_count  (check_count),
        .error_count  (error_count)
    );

    function automatic mem_pkg::lane_req_t make_lane(input logic valid,
                                                     input mem_pkg::addr_t addr,
                                                     input mem_pkg::msize_t msize,
                                                     input logic sext);
        mem_pkg::lane_req_t l;
        l.valid = valid;
        l.addr  = addr;
        l.msize = msize;
        l.sext  = sext;
        return l;
    endfunction

    // three in four lanes valid, any address so bit 29 varies too
    function automatic mem_pkg::lane_req_t random_lane();
        mem_pkg::lane_req_t l;
        l.valid = (($urandom % 4) != 0);
        l.addr  = $urandom;
        l.msize = mem_pkg::msize_t'($urandom % 3);
        l.sext  = 1'($urandom % 2);
        return l;
    endfunction

    task automatic send_bundle(input mem_pkg::lane_req_t l0, input mem_pkg::lane_req_t l1);
        int n;
        n = 0;
        if (abort) begin
            return;
        end
        while (!bundle_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!bundle_ready) begin
            $display("timeout, bundle_ready stayed low for %0d cycles", WAIT_LIMIT);
            timeout_count++;
            abort = 1'b1;
        end else begin
            lane0        = l0;
            lane1        = l1;
            bundle_valid = 1'b1;
            @(negedge clk);
            bundle_valid = 1'b0;
            // junk on the inputs, the DUT must work from its registered copy
            lane0 = random_lane();
            lane1 = random_lane();
        end
    endtask

    task automatic take_result(input int gap);
        int n;
        n = 0;
        if (abort) begin
            return;
        end
        while (!result_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!result_valid) begin
            $display("timeout, result_valid stayed low for %0d cycles", WAIT_LIMIT);
            timeout_count++;
            abort = 1'b1;
        end else begin
            repeat (gap) @(negedge clk);
            result_ready = 1'b1;
            @(negedge clk);
            result_ready = 1'b0;
        end
    endtask

    task automatic run_bundle(input mem_pkg::lane_req_t l0, input mem_pkg::lane_req_t l1,
                              input int gap);
        send_bundle(l0, l1);
        take_result(gap);
    endtask

    initial begin
        mem_pkg::lane_req_t l0;
        mem_pkg::lane_req_t l1;
        int                 gap;
        seed_val      = $urandom(SEED);
        resetn        = 1'b1;
        bundle_valid  = 1'b0;
        result_ready  = 1'b0;
        lane0         = '0;
        lane1         = '0;
        abort         = 1'b0;
        timeout_count = 0;
        // reset is active high
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;
        @(negedge clk);

        // word loads, both cached, low bits ignored
        for (int i = 0; i < 8; i++) begin
            run_bundle(make_lane(1'b1, i * 8 + (i % 4), mem_pkg::MSIZE_WORD, 1'b0),
                       make_lane(1'b1, 32'h0100_0004 + i * 8, mem_pkg::MSIZE_WORD, 1'(i)), 0);
        end

        // bytes and halves at every offset, both extend modes
        for (int s = 0; s < 2; s++) begin
            for (int off = 0; off < 4; off++) begin
                run_bundle(make_lane(1'b1, 32'h10 + off, mem_pkg::MSIZE_BYTE, 1'(s)),
                           make_lane(1'b1, 32'h14 + off, mem_pkg::MSIZE_HALF, 1'(s)), 0);
                run_bundle(make_lane(1'b1, 32'h10 + off, mem_pkg::MSIZE_HALF, 1'(s)),
                           make_lane(1'b1, 32'h14 + off, mem_pkg::MSIZE_BYTE, 1'(s)), 0);
            end
        end

        // uncached lane answers last
        run_bundle(make_lane(1'b1, 32'h2000_0008, mem_pkg::MSIZE_WORD, 1'b0),
                   make_lane(1'b1, 32'h0000_000e, mem_pkg::MSIZE_HALF, 1'b1), 0);
        run_bundle(make_lane(1'b1, 32'h0000_0023, mem_pkg::MSIZE_BYTE, 1'b1),
                   make_lane(1'b1, 32'h2000_0024, mem_pkg::MSIZE_WORD, 1'b0), 0);
        run_bundle(make_lane(1'b1, 32'h2000_0051, mem_pkg::MSIZE_BYTE, 1'b1),
                   make_lane(1'b1, 32'h2000_0056, mem_pkg::MSIZE_HALF, 1'b1), 0);

        // invalid lanes read zero
        run_bundle(make_lane(1'b0, 32'h2000_0030, mem_pkg::MSIZE_WORD, 1'b0),
                   make_lane(1'b1, 32'h0000_0034, mem_pkg::MSIZE_WORD, 1'b0), 0);
        run_bundle(make_lane(1'b1, 32'h2000_0038, mem_pkg::MSIZE_BYTE, 1'b1),
                   make_lane(1'b0, 32'h0000_003c, mem_pkg::MSIZE_WORD, 1'b0), 0);
        run_bundle(make_lane(1'b0, 32'h0000_0040, mem_pkg::MSIZE_HALF, 1'b1),
                   make_lane(1'b0, 32'h2000_0044, mem_pkg::MSIZE_WORD, 1'b0), 0);

        // long back-pressure stretches
        for (int i = 0; i < 10; i++) begin
            l0  = random_lane();
            l1  = random_lane();
            gap = $urandom % 12;
            run_bundle(l0, l1, gap);
        end

        for (int i = 0; i < 200; i++) begin
            l0  = random_lane();
            l1  = random_lane();
            gap = $urandom % 5;
            run_bundle(l0, l1, gap);
        end

        assert_fails = dut.u_ctrl.u_checker.assert_fails;
        $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 check_count, error_count, assert_fails, timeout_count);
        if (error_count == 0 && assert_fails == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dmem_init.hex
// one 32-bit data word per line, hex, word index 0 to 31
// the index is load address bits 6:2
8badf00d
12345678
fedcba98
7f80017e
80ff7f00
deadbeef
01020304
a5c35a3c
ffff0000
0000ffff
13579bdf
2468ace0
c001d00d
6b8e41f2
99aa55cc
0f1e2d3c
f0e1d2c3
4b5a6978
87654321
3c3c9696
e7e81899
55aa7f81
b1c2d3e4
7a3ec0d5
90817263
5f4e3d2c
ad4be1c7
18273645
e0d0c0b0
0a0b0c0d
c8f4a217
6d9e3b85

//--- verilog.f
source/mem_pkg.sv
source/dbus_if.sv
source/latency_timer.sv
source/bundle_ctrl.sv
source/load_lane.sv
source/dual_port_dmem.sv
source/mem_stage_top.sv
tests/tb_clock.sv
tests/mem_stage_checker.sv
tests/mem_stage_monitor.sv
tests/mem_stage_tb.sv
